//--- design/flow_pkg.sv
/*
 * Shared definitions for the flow serializer
 * Packet and flit widths, flit count, flit index width and serialization order
 * Vector typedefs for packets, flits and flit indices
 */

`default_nettype none

package flow_pkg;

  // ------------------------------------------------------------------
  // Widths and counts
  // ------------------------------------------------------------------

  // Width of one wide packet on the push side
  localparam int push_width = 32;
  // Width of one flit on the pop side
  localparam int pop_width = 8;
  // Each packet is split into this many flits
  localparam int num_pop_flits = push_width / pop_width;
  // Enough bits to number every flit of a packet
  localparam int flit_id_width = $clog2(num_pop_flits);

  // ------------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------------

  typedef logic [push_width-1:0] push_data_t;
  typedef logic [pop_width-1:0] pop_data_t;
  typedef logic [flit_id_width-1:0] flit_id_t;

  // Index of the final flit in a packet
  localparam flit_id_t max_flit_id = flit_id_t'(num_pop_flits - 1);

  // Set to send the most significant slice of a packet first
  localparam bit serialize_msb_first = 1'b1;

endpackage : flow_pkg

`default_nettype wire

//--- design/flow_counter.sv
/*
 * Wrapping flit index counter
 * Steps by one on each enable and returns to zero after the last flit index
 */

`timescale 1ns/1ps
`default_nettype none

module flow_counter (
  input  logic              clk,
  input  logic              arst_n,
  // Advance the index on this cycle
  input  logic              incr_valid,
  // Current flit index
  output flow_pkg::flit_id_t value
);

  import flow_pkg::*;

  // Index that the counter takes on its next enabled edge
  flit_id_t value_next;

  // ------------------------------------------------------------------
  // Next value with wrap
  // ------------------------------------------------------------------

  // Wrap explicitly so the count also works when the flit count
  // is not a power of two
  always_comb begin
    if (value == max_flit_id) begin
      value_next = '0;
    end else begin
      value_next = value + flit_id_t'(1);
    end
  end

  // ------------------------------------------------------------------
  // Index register
  // ------------------------------------------------------------------

  // The count moves one cycle after the enable and starts at flit zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value <= '0;
    end else if (incr_valid) begin
      value <= value_next;
    end
  end

endmodule : flow_counter

`default_nettype wire

//--- design/flow_reg_fwd.sv
/*
 * One-entry forward register for a ready-valid flow
 * Registers valid and data with one cycle of latency at full throughput
 */

`timescale 1ns/1ps
`default_nettype none

module flow_reg_fwd #(
  // Payload width in bits
  parameter int width = 1
) (
  input  logic             clk,
  input  logic             arst_n,

  // Upstream side
  input  logic             push_valid,
  output logic             push_ready,
  input  logic [width-1:0] push_data,

  // Downstream side
  output logic             pop_valid,
  input  logic             pop_ready,
  output logic [width-1:0] pop_data
);

  // Holding register state
  logic             valid_q;
  logic [width-1:0] data_q;
  // A new item is captured on this cycle
  logic             load;

  // ------------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------------

  // The stage takes a new item when it is empty or its item is leaving,
  // which keeps one item per cycle moving under steady flow
  assign push_ready = !valid_q || pop_ready;
  assign load = push_valid && push_ready;

  // ------------------------------------------------------------------
  // Valid register
  // ------------------------------------------------------------------

  // While downstream stalls a full stage keeps its item
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (push_ready) begin
      valid_q <= push_valid;
    end
  end

  // ------------------------------------------------------------------
  // Data register
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= push_data;
    end
  end

  // Outputs come straight from the registers
  assign pop_valid = valid_q;
  assign pop_data = data_q;

endmodule : flow_reg_fwd

`default_nettype wire

//--- design/flow_serializer.sv
/*
 * Wide-to-narrow flow serializer
 * Splits each push packet into flits with a flit index and a last flag
 * The pop side can pass through a forward register
 */

`timescale 1ns/1ps
`default_nettype none

module flow_serializer #(
  // Set to put a forward register on the pop side
  parameter bit register_pop_outputs = 1'b0
) (
  input  logic                 clk,
  input  logic                 arst_n,

  // Push side with one wide packet per transfer
  input  logic                 push_valid,
  output logic                 push_ready,
  input  flow_pkg::push_data_t push_data,

  // Pop side with one flit per transfer
  output logic                 pop_valid,
  input  logic                 pop_ready,
  output flow_pkg::pop_data_t  pop_data,
  output flow_pkg::flit_id_t   pop_id,
  output logic                 pop_last
);

  import flow_pkg::*;

  // Flit stream ahead of the optional output register
  logic      internal_pop_valid;
  logic      internal_pop_ready;
  pop_data_t internal_pop_data;
  flit_id_t  internal_pop_id;
  logic      internal_pop_last;
  // Which slice of the packet is on the flit stream now
  flit_id_t  slice_id;

  // ------------------------------------------------------------------
  // Flit index
  // ------------------------------------------------------------------

  // One step per flit taken by the internal pop stage
  flow_counter u_flit_counter (
    .clk        (clk),
    .arst_n     (arst_n),
    .incr_valid (internal_pop_valid && internal_pop_ready),
    .value      (internal_pop_id)
  );

  // The final flit of a packet carries the last flag
  assign internal_pop_last = (internal_pop_id == max_flit_id);

  // ------------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------------

  // A presented packet always has a flit to offer
  assign internal_pop_valid = push_valid;

  // The packet stays on the push port until its final flit is taken,
  // so the push transfer lines up with that last flit
  assign push_ready = internal_pop_ready && internal_pop_last;

  // ------------------------------------------------------------------
  // Slice selection
  // ------------------------------------------------------------------

  // Mirror the index when the top slice must leave first
  assign slice_id = serialize_msb_first ? (max_flit_id - internal_pop_id) : internal_pop_id;

  // Slice zero holds the least significant bits of the packet
  assign internal_pop_data = push_data[slice_id * pop_width +: pop_width];

  // ------------------------------------------------------------------
  // Pop side
  // ------------------------------------------------------------------

  if (register_pop_outputs) begin : gen_pop_reg
    // Data, index and last flag travel through one register together
    // and add one cycle before the first flit
    flow_reg_fwd #(
      .width (pop_width + flit_id_width + 1)
    ) u_pop_reg (
      .clk        (clk),
      .arst_n     (arst_n),
      .push_valid (internal_pop_valid),
      .push_ready (internal_pop_ready),
      .push_data  ({internal_pop_data, internal_pop_id, internal_pop_last}),
      .pop_valid  (pop_valid),
      .pop_ready  (pop_ready),
      .pop_data   ({pop_data, pop_id, pop_last})
    );
  end else begin : gen_pop_comb
    // First flit leaves in the same cycle that the packet arrives
    assign internal_pop_ready = pop_ready;
    assign pop_valid = internal_pop_valid;
    assign pop_data = internal_pop_data;
    assign pop_id = internal_pop_id;
    assign pop_last = internal_pop_last;
  end

endmodule : flow_serializer

`default_nettype wire

//--- design/flow_serializer_top.sv
/*
 * Top level of the flow serializer subsystem
 * Serializer configured with a registered pop side
 */

`timescale 1ns/1ps
`default_nettype none

module flow_serializer_top (
  input  logic                 clk,
  input  logic                 arst_n,

  // Wide packets in
  input  logic                 push_valid,
  output logic                 push_ready,
  input  flow_pkg::push_data_t push_data,

  // Flits out
  output logic                 pop_valid,
  input  logic                 pop_ready,
  output flow_pkg::pop_data_t  pop_data,
  output flow_pkg::flit_id_t   pop_id,
  output logic                 pop_last
);

  // ------------------------------------------------------------------
  // Serializer
  // ------------------------------------------------------------------

  // Registered pop side so the first flit trails the packet by a cycle
  // and every pop output comes from a flop
  flow_serializer #(
    .register_pop_outputs (1'b1)
  ) u_serializer (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data),
    .pop_id     (pop_id),
    .pop_last   (pop_last)
  );

endmodule : flow_serializer_top

`default_nettype wire

//--- testbench/tb_flow_serializer_top.sv
/*
 * Testbench for the flow serializer top level
 * Random packets with random pop back-pressure, reference flit model,
 * monitor that checks every pop and push transfer
 */

`timescale 1ns/1ps
`default_nettype none

module tb_flow_serializer_top;

  import flow_pkg::*;

  // Cycles to wait for a packet to be accepted or for the flits to drain
  localparam int wait_limit = 200;

  logic       clk;
  logic       arst_n;
  logic       push_valid;
  logic       push_ready;
  push_data_t push_data;
  logic       pop_valid;
  logic       pop_ready;
  pop_data_t  pop_data;
  flit_id_t   pop_id;
  logic       pop_last;

  // Packets presented to the DUT whose flits are still due
  push_data_t exp_q[$];
  // Expected flit as {data, id, last}
  logic [pop_width+flit_id_width:0] exp_flit;

  logic [31:0] pkt_state = 32'd49034;
  logic [31:0] rdy_state = ~32'd49034;
  bit          random_ready = 1'b0;
  bit          gap_check = 1'b0;
  bit          latency_armed = 1'b0;
  bit          timed_out = 1'b0;
  bit          stall_seen = 1'b0;
  pop_data_t   held_data;
  flit_id_t    held_id;
  logic        held_last;
  int          cycle = 0;
  int          rise_cycle = 0;
  int          last_xfer_cycle = -1;
  int          flit_idx = 0;
  int          sent = 0;
  int          accepted = 0;
  int          last_seen = 0;
  int          flits_seen = 0;
  int          mismatches = 0;
  int          timeouts = 0;

  flow_serializer_top dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data),
    .pop_id     (pop_id),
    .pop_last   (pop_last)
  );

  // ------------------------------------------------------------------
  // Clock, cycle count and random numbers
  // ------------------------------------------------------------------

  always #10 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Flit idx counted from the top of the packet, with its id and last flag
  function automatic logic [pop_width+flit_id_width:0] expected_flit(
    input push_data_t pkt,
    input int         idx
  );
    push_data_t shifted;
    pop_data_t  slice;
    flit_id_t   id;
    // Move the wanted slice up to the most significant end
    shifted = pkt << (idx * pop_width);
    slice = shifted[push_width-1 -: pop_width];
    id = flit_id_t'(idx);
    return {slice, id, (idx == num_pop_flits - 1)};
  endfunction

  // Ready is 1 in streaming phases and random at 75 percent otherwise
  initial begin
    forever begin
      @(posedge clk);
      #1;
      rdy_state = xorshift32(rdy_state);
      pop_ready = random_ready ? (rdy_state[1:0] != 2'b00) : 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // Driver tasks
  // ------------------------------------------------------------------

  // Starts and ends 1 ns after a rising edge
  task automatic send_packet(input bit allow_gap);
    int gap;
    int waited;
    bit taken;
    if (!timed_out) begin
      pkt_state = xorshift32(pkt_state);
      gap = allow_gap ? int'(pkt_state[1:0]) : 0;
      if (gap > 0) begin
        push_valid = 1'b0;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
      pkt_state = xorshift32(pkt_state);
      // A packet that meets an empty stage shows its first flit next cycle
      if (!push_valid && !pop_valid) begin
        rise_cycle = cycle;
        latency_armed = 1'b1;
      end
      push_data = pkt_state;
      push_valid = 1'b1;
      exp_q.push_back(pkt_state);
      sent++;
      waited = 0;
      taken = 1'b0;
      while (!taken && !timed_out) begin
        @(negedge clk);
        if (push_ready) begin
          taken = 1'b1;
        end else begin
          waited++;
          if (waited > wait_limit) begin
            $display("Timeout: packet %0d was never accepted by the DUT", sent);
            timeouts++;
            timed_out = 1'b1;
          end
        end
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && !timed_out) begin
      @(posedge clk);
      waited++;
      if (waited > wait_limit) begin
        $display("Timeout: %0d packets still had flits due on the pop port", exp_q.size());
        timeouts++;
        timed_out = 1'b1;
      end
    end
    @(posedge clk);
    #1;
  endtask

  // ------------------------------------------------------------------
  // Stimulus sequence
  // ------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    push_valid = 1'b0;
    push_data = '0;
    pop_ready = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    repeat (3) begin
      @(posedge clk);
      #1;
    end

    // Back-to-back packets with ready held high must stream with no gap
    gap_check = 1'b1;
    for (int i = 0; i < 8; i++) begin
      send_packet(1'b0);
    end
    push_valid = 1'b0;
    wait_drained();
    gap_check = 1'b0;

    // Random idle gaps and random back-pressure
    @(negedge clk);
    random_ready = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < 40; i++) begin
      send_packet(1'b1);
    end
    push_valid = 1'b0;
    wait_drained();
    @(negedge clk);
    random_ready = 1'b0;

    if (!timed_out) begin
      if (accepted != sent) begin
        $display("Mismatch at %0t: %0d packets accepted, %0d sent", $time, accepted, sent);
        mismatches++;
      end
      if (last_seen != accepted) begin
        $display("Mismatch at %0t: %0d last flits, %0d packets accepted",
                 $time, last_seen, accepted);
        mismatches++;
      end
      if (flits_seen != sent * num_pop_flits) begin
        $display("Mismatch at %0t: %0d flits seen, %0d expected",
                 $time, flits_seen, sent * num_pop_flits);
        mismatches++;
      end
    end

    $display("Summary: %0d packets, %0d flits, %0d mismatches, %0d timeouts",
             sent, flits_seen, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // ------------------------------------------------------------------
  // Monitor
  // ------------------------------------------------------------------

  // Sampled mid-cycle, so a transfer seen here happens on the next edge
  always @(negedge clk) begin
    // A stalled flit must stay put until it is taken
    if (stall_seen) begin
      if (pop_valid !== 1'b1 || pop_data !== held_data || pop_id !== held_id ||
          pop_last !== held_last) begin
        $display("Mismatch at %0t: pop outputs changed while stalled", $time);
        mismatches++;
      end
    end
    stall_seen = pop_valid && !pop_ready;
    held_data = pop_data;
    held_id = pop_id;
    held_last = pop_last;

    // Nothing may leave or be accepted with no packet outstanding
    if (exp_q.size() == 0) begin
      if (pop_valid !== 1'b0 || push_ready !== 1'b0) begin
        $display("Mismatch at %0t: pop_valid %b push_ready %b with no packet pending",
                 $time, pop_valid, push_ready);
        mismatches++;
      end
    end

    if (latency_armed && cycle == rise_cycle + 1) begin
      latency_armed = 1'b0;
      if (pop_valid !== 1'b1) begin
        $display("Mismatch at %0t: first flit not out one cycle after push_valid", $time);
        mismatches++;
      end
    end

    // Every flit that leaves is counted, whether one was due or not
    if (pop_valid === 1'b1 && pop_ready) begin
      flits_seen++;
    end

    if (pop_valid === 1'b1 && pop_ready && exp_q.size() > 0) begin
      exp_flit = expected_flit(exp_q[0], flit_idx);
      if ({pop_data, pop_id, pop_last} !== exp_flit) begin
        $display("Mismatch at %0t: flit %0d of %h wants data %h id %0d last %b, got %h %0d %b",
                 $time, flit_idx, exp_q[0], exp_flit[flit_id_width+pop_width -: pop_width],
                 exp_flit[flit_id_width:1], exp_flit[0], pop_data, pop_id, pop_last);
        mismatches++;
      end
      if (gap_check && last_xfer_cycle >= 0 && cycle != last_xfer_cycle + 1) begin
        $display("Mismatch at %0t: gap of %0d cycles in a streaming flow",
                 $time, cycle - last_xfer_cycle - 1);
        mismatches++;
      end
      last_xfer_cycle = cycle;
      if (pop_last) last_seen++;
      if (flit_idx == num_pop_flits - 1) begin
        void'(exp_q.pop_front());
        flit_idx = 0;
      end else begin
        flit_idx++;
      end
    end

    // Every push_ready pulse must be a push transfer in step with its last flit
    if (push_ready === 1'b1) begin
      accepted++;
      if (push_valid !== 1'b1 || exp_q.size() == 0 || push_data !== exp_q[0] ||
          flit_idx != num_pop_flits - 1) begin
        $display("Mismatch at %0t: push_ready for %h not in step with its last flit",
                 $time, push_data);
        mismatches++;
      end
    end
  end

endmodule : tb_flow_serializer_top

`default_nettype wire

//--- build.f
design/flow_pkg.sv
design/flow_counter.sv
design/flow_reg_fwd.sv
design/flow_serializer.sv
design/flow_serializer_top.sv
testbench/tb_flow_serializer_top.sv

//--- Bender.yml
package:
  name: flow_serializer

dependencies: {}

sources:
  # Design sources in compile order
  - files:
      - design/flow_pkg.sv
      - design/flow_counter.sv
      - design/flow_reg_fwd.sv
      - design/flow_serializer.sv
      - design/flow_serializer_top.sv

  # Testbench, only for simulation
  - target: test
    files:
      - testbench/tb_flow_serializer_top.sv
